/* compile.f */
+incdir+.
csr_pkg.sv
csr_bus_fsm.sv
csr_timer.sv
csr_trap_regs.sv
csr_save_regs.sv
csr_unit.sv
tb_csr_unit.sv

/* Bender.yml */
package:
  name: csr_unit

export_include_dirs:
  - .

sources:
  - files:
      - csr_pkg.sv
      - csr_bus_fsm.sv
      - csr_timer.sv
      - csr_trap_regs.sv
      - csr_save_regs.sv
      - csr_unit.sv
  - target: test
    files:
      - tb_csr_unit.sv

/* tb_csr_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "csr_defines.svh"

module tb_csr_unit;

    import csr_pkg::*;

    localparam int ACK_TIMEOUT   = 20;
    localparam int POLL_TIMEOUT  = 60;
    localparam int DRAIN_TIMEOUT = 10;
    localparam int CMP_EQ = 0;
    localparam int CMP_LE = 1;
    localparam int CMP_GE = 2;
    localparam int CMP_GT = 3;
    localparam int CMP_NE = 4;

    logic       clk = 1'b0;
    logic       rst;
    logic       wb_cyc_i;
    logic       wb_stb_i;
    logic       wb_we_i;
    csr_addr_t  wb_adr_i;
    csr_data_t  wb_dat_i;
    logic       wb_ack_o;
    csr_data_t  wb_dat_o;
    logic       excp_flush_i;
    logic       ertn_flush_i;
    ecode_t     ecode_i;
    esubcode_t  esubcode_i;
    csr_data_t  era_i;
    hw_int_t    interrupt_i;
    logic       has_int_o;
    plv_t       plv_o;
    csr_data_t  eentry_o;
    csr_data_t  era_o;
    logic [63:0] timer_64_o;
    csr_data_t  tid_o;

    logic [31:0] lcg_state;
    int          check_count;
    int          error_count;
    int          timeout_count;

    // pending comparisons, drained by the compare process
    string       chk_name_q [$];
    int          chk_kind_q [$];
    logic [63:0] chk_exp_q  [$];
    logic [63:0] chk_act_q  [$];

    csr_unit csr_unit_inst (
        .clk          (clk),
        .rst          (rst),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_ack_o     (wb_ack_o),
        .wb_dat_o     (wb_dat_o),
        .excp_flush_i (excp_flush_i),
        .ertn_flush_i (ertn_flush_i),
        .ecode_i      (ecode_i),
        .esubcode_i   (esubcode_i),
        .era_i        (era_i),
        .interrupt_i  (interrupt_i),
        .has_int_o    (has_int_o),
        .plv_o        (plv_o),
        .eentry_o     (eentry_o),
        .era_o        (era_o),
        .timer_64_o   (timer_64_o),
        .tid_o        (tid_o)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // read-back value after a bus write, from the register write masks
    function automatic csr_data_t expected_readback(input csr_addr_t addr, input csr_data_t wdata);
        csr_data_t r;
        r = '0;
        case (addr)
            `CSR_CRMD: begin
                r = `CSR_CRMD_RST;
                r[`CSR_CRMD_PLV] = wdata[`CSR_CRMD_PLV];
                r[`CSR_CRMD_IE]  = wdata[`CSR_CRMD_IE];
            end
            `CSR_PRMD: begin
                r[`CSR_PRMD_PPLV] = wdata[`CSR_PRMD_PPLV];
                r[`CSR_PRMD_PIE]  = wdata[`CSR_PRMD_PIE];
            end
            `CSR_ECTL:   r[`CSR_ECTL_LIE] = wdata[`CSR_ECTL_LIE];
            `CSR_EENTRY: r = {wdata[31:6], 6'b000000};
            `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3: r = wdata;
            `CSR_ERA, `CSR_TID, `CSR_TCFG, `CSR_CNTC: r = wdata;
            default:     r = '0;
        endcase
        return r;
    endfunction

    function automatic string relation_text(input int kind);
        case (kind)
            CMP_LE:  return "<=";
            CMP_GE:  return ">=";
            CMP_GT:  return ">";
            CMP_NE:  return "!=";
            default: return "==";
        endcase
    endfunction

    task automatic expect_wide(input string name, input int kind, input logic [63:0] exp_val,
                               input logic [63:0] act_val);
        chk_name_q.push_back(name);
        chk_kind_q.push_back(kind);
        chk_exp_q.push_back(exp_val);
        chk_act_q.push_back(act_val);
    endtask

    task automatic expect_value(input string name, input int kind, input csr_data_t exp_val,
                                input csr_data_t act_val);
        expect_wide(name, kind, {32'h0, exp_val}, {32'h0, act_val});
    endtask

    task automatic stop_on_timeout(input string what);
        timeout_count++;
        $display("timeout while waiting for %s", what);
        $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeout_count);
        $display("TESTS FAILED");
        $finish;
    endtask

    // one classic cycle, request held until ack, then stb dropped
    task automatic run_bus_cycle(input logic we, input csr_addr_t addr, input csr_data_t wdata,
                                 output csr_data_t rdata);
        int waited;
        waited = 0;
        rdata = '0;
        @(posedge clk);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= addr;
        wb_dat_i <= wdata;
        @(negedge clk);
        while (!wb_ack_o && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!wb_ack_o) begin
            stop_on_timeout("bus ack");
        end else begin
            rdata = wb_dat_o;
            @(posedge clk);
            wb_cyc_i <= 1'b0;
            wb_stb_i <= 1'b0;
            wb_we_i  <= 1'b0;
            @(negedge clk);
            expect_value("ack one cycle", CMP_EQ, 32'h0, {31'h0, wb_ack_o});
        end
    endtask

    task automatic write_csr(input csr_addr_t addr, input csr_data_t wdata);
        csr_data_t unused;
        run_bus_cycle(1'b1, addr, wdata, unused);
    endtask

    task automatic read_csr(input csr_addr_t addr, output csr_data_t rdata);
        run_bus_cycle(1'b0, addr, '0, rdata);
    endtask

    always @(negedge clk) begin : compare_results
        string       n;
        int          k;
        logic [63:0] e;
        logic [63:0] a;
        logic        bad;
        while (chk_name_q.size() != 0) begin
            n = chk_name_q.pop_front();
            k = chk_kind_q.pop_front();
            e = chk_exp_q.pop_front();
            a = chk_act_q.pop_front();
            bad = 1'b0;
            if ($isunknown(a)) bad = 1'b1;
            if (k == CMP_EQ && a != e) bad = 1'b1;
            if (k == CMP_LE && a > e) bad = 1'b1;
            if (k == CMP_GE && a < e) bad = 1'b1;
            if (k == CMP_GT && a <= e) bad = 1'b1;
            if (k == CMP_NE && a == e) bad = 1'b1;
            check_count++;
            if (bad) begin
                error_count++;
                $display("FAIL %s expected %s 0x%0h actual 0x%0h", n, relation_text(k), e, a);
            end
        end
    end

    initial begin
        csr_addr_t   rb_addr [8];
        csr_data_t   w;
        csr_data_t   rd;
        csr_data_t   era_val;
        csr_data_t   exp_word;
        ecode_t      ec;
        esubcode_t   es;
        hw_int_t     irq;
        int          i;
        int          k;
        int          polls;
        int          round;
        int          drain;
        logic        seen;
        logic [63:0] s0;
        logic [63:0] s1;
        logic [63:0] s2;

        lcg_state     = 32'd93;
        check_count   = 0;
        error_count   = 0;
        timeout_count = 0;
        rst          <= 1'b1;
        wb_cyc_i     <= 1'b0;
        wb_stb_i     <= 1'b0;
        wb_we_i      <= 1'b0;
        wb_adr_i     <= '0;
        wb_dat_i     <= '0;
        excp_flush_i <= 1'b0;
        ertn_flush_i <= 1'b0;
        ecode_i      <= '0;
        esubcode_i   <= '0;
        era_i        <= '0;
        interrupt_i  <= '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // state right after reset
        @(negedge clk);
        expect_value("wb_ack_o after reset", CMP_EQ, 32'h0, {31'h0, wb_ack_o});
        expect_value("has_int_o after reset", CMP_EQ, 32'h0, {31'h0, has_int_o});
        expect_value("plv_o after reset", CMP_EQ, 32'h0, {30'h0, plv_o});

        // masked read-back
        rb_addr = '{`CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3,
                    `CSR_EENTRY, `CSR_ECTL, `CSR_PRMD, `CSR_TID};
        for (i = 0; i < 8; i++) begin
            w = lcg_next();
            write_csr(rb_addr[i], w);
            read_csr(rb_addr[i], rd);
            expect_value($sformatf("readback 0x%0h", rb_addr[i]), CMP_EQ,
                         expected_readback(rb_addr[i], w), rd);
            if (rb_addr[i] == `CSR_TID) begin
                expect_value("tid_o", CMP_EQ, w, tid_o);
            end
            if (rb_addr[i] == `CSR_EENTRY) begin
                expect_value("eentry_o", CMP_EQ, expected_readback(`CSR_EENTRY, w), eentry_o);
            end
        end
        write_csr(14'h100, lcg_next());
        read_csr(14'h100, rd);
        expect_value("unmapped readback", CMP_EQ, 32'h0, rd);

        // exception entry and return
        write_csr(`CSR_CRMD, 32'h7);
        @(negedge clk);
        expect_value("plv_o before entry", CMP_EQ, 32'd3, {30'h0, plv_o});
        w = lcg_next();
        ec = w[21:16];
        es = w[30:22];
        era_val = lcg_next();
        @(posedge clk);
        excp_flush_i <= 1'b1;
        ecode_i      <= ec;
        esubcode_i   <= es;
        era_i        <= era_val;
        @(posedge clk);
        excp_flush_i <= 1'b0;
        @(negedge clk);
        expect_value("plv_o after entry", CMP_EQ, 32'd0, {30'h0, plv_o});
        expect_value("era_o after entry", CMP_EQ, era_val, era_o);
        read_csr(`CSR_CRMD, rd);
        expect_value("crmd after entry", CMP_EQ, expected_readback(`CSR_CRMD, 32'h0), rd);
        read_csr(`CSR_PRMD, rd);
        expect_value("prmd after entry", CMP_EQ, expected_readback(`CSR_PRMD, 32'h7), rd);
        read_csr(`CSR_ERA, rd);
        expect_value("era after entry", CMP_EQ, era_val, rd);
        exp_word = '0;
        exp_word[`CSR_ESTAT_ECODE] = ec;
        exp_word[`CSR_ESTAT_ESUB]  = es;
        read_csr(`CSR_ESTAT, rd);
        expect_value("estat after entry", CMP_EQ, exp_word, rd);
        @(posedge clk);
        ertn_flush_i <= 1'b1;
        @(posedge clk);
        ertn_flush_i <= 1'b0;
        @(negedge clk);
        expect_value("plv_o after return", CMP_EQ, 32'd3, {30'h0, plv_o});
        read_csr(`CSR_CRMD, rd);
        expect_value("crmd after return", CMP_EQ, expected_readback(`CSR_CRMD, 32'h7), rd);

        // one-shot timer, INITVAL 8
        write_csr(`CSR_ECTL, 32'h800);
        write_csr(`CSR_TCFG, (32'd8 << 2) | 32'h1);
        read_csr(`CSR_TVAL, rd);
        expect_value("tval after load", CMP_LE, 32'd32, rd);
        polls = 0;
        seen  = 1'b0;
        while (!seen && polls < POLL_TIMEOUT) begin
            read_csr(`CSR_ESTAT, rd);
            seen = rd[`CSR_ESTAT_TI];
            polls++;
        end
        if (!seen) begin
            stop_on_timeout("one-shot timer interrupt");
        end
        read_csr(`CSR_TVAL, rd);
        expect_value("tval after one-shot", CMP_EQ, 32'hffff_ffff, rd);
        read_csr(`CSR_TVAL, rd);
        expect_value("tval stays expired", CMP_EQ, 32'hffff_ffff, rd);
        @(negedge clk);
        expect_value("has_int_o timer", CMP_EQ, 32'd1, {31'h0, has_int_o});
        write_csr(`CSR_TICLR, 32'h1);
        read_csr(`CSR_ESTAT, rd);
        expect_value("estat ti cleared", CMP_EQ, 32'h0, rd & 32'h800);
        expect_value("has_int_o after clear", CMP_EQ, 32'd0, {31'h0, has_int_o});

        // periodic timer, INITVAL 4
        write_csr(`CSR_TCFG, (32'd4 << 2) | 32'h3);
        for (round = 0; round < 2; round++) begin
            write_csr(`CSR_TICLR, 32'h1);
            polls = 0;
            seen  = 1'b0;
            while (!seen && polls < POLL_TIMEOUT) begin
                read_csr(`CSR_TVAL, rd);
                expect_value("periodic tval", CMP_NE, 32'hffff_ffff, rd);
                read_csr(`CSR_ESTAT, rd);
                seen = rd[`CSR_ESTAT_TI];
                polls++;
            end
            if (!seen) begin
                stop_on_timeout("periodic timer interrupt");
            end
        end
        write_csr(`CSR_TCFG, 32'h0);
        write_csr(`CSR_TICLR, 32'h1);

        // hardware interrupt on one random line
        w = lcg_next();
        k = w % 9;
        irq = 9'd1 << k;
        write_csr(`CSR_ECTL, 32'h1 << (k + 2));
        @(posedge clk);
        interrupt_i <= irq;
        @(posedge clk);
        @(negedge clk);
        expect_value("has_int_o hw line", CMP_EQ, 32'd1, {31'h0, has_int_o});
        read_csr(`CSR_ESTAT, rd);
        expect_value("estat hw lines", CMP_EQ, {23'h0, irq}, {23'h0, rd[`CSR_ESTAT_HWI]});
        write_csr(`CSR_CRMD, 32'h3);
        @(negedge clk);
        expect_value("has_int_o with ie clear", CMP_EQ, 32'd0, {31'h0, has_int_o});
        @(posedge clk);
        interrupt_i <= '0;

        // stable counter and CNTC offset
        @(negedge clk);
        s0 = timer_64_o;
        repeat (3) @(negedge clk);
        s1 = timer_64_o;
        expect_wide("stable counter increases", CMP_GT, s0, s1);
        write_csr(`CSR_CNTC, 32'h1000_0000);
        @(negedge clk);
        s2 = timer_64_o;
        expect_wide("timer_64_o with cntc", CMP_GE, s1 + 64'h1000_0000, s2);

        drain = 0;
        while (chk_name_q.size() != 0 && drain < DRAIN_TIMEOUT) begin
            @(negedge clk);
            drain++;
        end
        if (chk_name_q.size() != 0) begin
            stop_on_timeout("result comparison");
        end else begin
            $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count,
                     timeout_count);
            if (error_count == 0 && timeout_count == 0) begin
                $display("TESTS PASSED");
            end else begin
                $display("TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* csr_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_unit (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     wb_cyc_i,
    input  wire                     wb_stb_i,
    input  wire                     wb_we_i,
    input  wire csr_pkg::csr_addr_t     wb_adr_i,
    input  wire csr_pkg::csr_data_t     wb_dat_i,
    output logic                    wb_ack_o,
    output csr_pkg::csr_data_t      wb_dat_o,
    input  wire                     excp_flush_i,
    input  wire                     ertn_flush_i,
    input  wire csr_pkg::ecode_t        ecode_i,
    input  wire csr_pkg::esubcode_t     esubcode_i,
    input  wire csr_pkg::csr_data_t     era_i,
    input  wire csr_pkg::hw_int_t       interrupt_i,
    output logic                    has_int_o,
    output csr_pkg::plv_t           plv_o,
    output csr_pkg::csr_data_t      eentry_o,
    output csr_pkg::csr_data_t      era_o,
    output logic [63:0]             timer_64_o,
    output csr_pkg::csr_data_t      tid_o
);

    import csr_pkg::*;

    logic      csr_we;
    csr_addr_t csr_addr;
    csr_data_t csr_wdata;
    csr_data_t trap_rdata;
    csr_data_t timer_rdata;
    csr_data_t save_rdata;
    logic      timer_irq;
    logic      timer_clr;

    csr_bus_fsm csr_bus_fsm_inst (
        .clk           (clk),
        .rst           (rst),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .trap_rdata_i  (trap_rdata),
        .timer_rdata_i (timer_rdata),
        .save_rdata_i  (save_rdata),
        .wb_ack_o      (wb_ack_o),
        .wb_dat_o      (wb_dat_o),
        .csr_we_o      (csr_we),
        .csr_addr_o    (csr_addr),
        .csr_wdata_o   (csr_wdata)
    );

    csr_timer csr_timer_inst (
        .clk         (clk),
        .rst         (rst),
        .csr_we_i    (csr_we),
        .csr_addr_i  (csr_addr),
        .csr_wdata_i (csr_wdata),
        .timer_clr_i (timer_clr),
        .rdata_o     (timer_rdata),
        .timer_irq_o (timer_irq),
        .timer_64_o  (timer_64_o),
        .tid_o       (tid_o)
    );

    csr_trap_regs csr_trap_regs_inst (
        .clk          (clk),
        .rst          (rst),
        .csr_we_i     (csr_we),
        .csr_addr_i   (csr_addr),
        .csr_wdata_i  (csr_wdata),
        .excp_flush_i (excp_flush_i),
        .ertn_flush_i (ertn_flush_i),
        .ecode_i      (ecode_i),
        .esubcode_i   (esubcode_i),
        .era_i        (era_i),
        .interrupt_i  (interrupt_i),
        .timer_irq_i  (timer_irq),
        .rdata_o      (trap_rdata),
        .timer_clr_o  (timer_clr),
        .has_int_o    (has_int_o),
        .plv_o        (plv_o),
        .eentry_o     (eentry_o),
        .era_o        (era_o)
    );

    csr_save_regs csr_save_regs_inst (
        .clk         (clk),
        .csr_we_i    (csr_we),
        .csr_addr_i  (csr_addr),
        .csr_wdata_i (csr_wdata),
        .rdata_o     (save_rdata)
    );

endmodule

`default_nettype wire

/* csr_save_regs.sv */
`timescale 1ns/100ps
`default_nettype none

`include "csr_defines.svh"

module csr_save_regs (
    input  wire                 clk,
    input  wire                 csr_we_i,
    input  wire csr_pkg::csr_addr_t csr_addr_i,
    input  wire csr_pkg::csr_data_t csr_wdata_i,
    output csr_pkg::csr_data_t  rdata_o
);

    import csr_pkg::*;

    csr_data_t  save_q [4];
    logic       hit;
    logic [1:0] idx;

    always_comb begin
        hit = 1'b1;
        case (csr_addr_i)
            `CSR_SAVE0: idx = 2'd0;
            `CSR_SAVE1: idx = 2'd1;
            `CSR_SAVE2: idx = 2'd2;
            `CSR_SAVE3: idx = 2'd3;
            default: begin
                idx = 2'd0;
                hit = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (csr_we_i && hit) begin
            save_q[idx] <= csr_wdata_i;
        end
    end

    assign rdata_o = hit ? save_q[idx] : '0;

endmodule

`default_nettype wire

/* csr_trap_regs.sv */
`timescale 1ns/100ps
`default_nettype none

`include "csr_defines.svh"

module csr_trap_regs (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    csr_we_i,
    input  wire csr_pkg::csr_addr_t    csr_addr_i,
    input  wire csr_pkg::csr_data_t    csr_wdata_i,
    input  wire                    excp_flush_i,
    input  wire                    ertn_flush_i,
    input  wire csr_pkg::ecode_t       ecode_i,
    input  wire csr_pkg::esubcode_t    esubcode_i,
    input  wire csr_pkg::csr_data_t    era_i,
    input  wire csr_pkg::hw_int_t      interrupt_i,
    input  wire                    timer_irq_i,
    output csr_pkg::csr_data_t     rdata_o,
    output logic                   timer_clr_o,
    output logic                   has_int_o,
    output csr_pkg::plv_t          plv_o,
    output csr_pkg::csr_data_t     eentry_o,
    output csr_pkg::csr_data_t     era_o
);

    import csr_pkg::*;

    plv_t        plv_q;
    logic        ie_q;
    plv_t        pplv_q;
    logic        pie_q;
    logic [12:0] lie_q;
    logic [1:0]  swi_q;
    hw_int_t     hwi_q;
    ecode_t      ecode_q;
    esubcode_t   esub_q;
    csr_data_t   era_q;
    logic [25:0] eentry_q;
    logic [12:0] is_vec;
    csr_data_t   crmd_word;
    csr_data_t   prmd_word;
    csr_data_t   ectl_word;
    csr_data_t   estat_word;

    function automatic logic wr_hit(input csr_addr_t a);
        return csr_we_i && (csr_addr_i == a);
    endfunction

    // crmd and prmd, entry wins over return and bus writes
    always_ff @(posedge clk) begin
        if (rst) begin
            plv_q  <= '0;
            ie_q   <= 1'b0;
            pplv_q <= '0;
            pie_q  <= 1'b0;
        end else if (excp_flush_i) begin
            pplv_q <= plv_q;
            pie_q  <= ie_q;
            plv_q  <= '0;
            ie_q   <= 1'b0;
        end else begin
            if (ertn_flush_i) begin
                plv_q <= pplv_q;
                ie_q  <= pie_q;
            end else if (wr_hit(`CSR_CRMD)) begin
                plv_q <= csr_wdata_i[`CSR_CRMD_PLV];
                ie_q  <= csr_wdata_i[`CSR_CRMD_IE];
            end
            if (wr_hit(`CSR_PRMD)) begin
                pplv_q <= csr_wdata_i[`CSR_PRMD_PPLV];
                pie_q  <= csr_wdata_i[`CSR_PRMD_PIE];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lie_q   <= '0;
            swi_q   <= '0;
            hwi_q   <= '0;
            ecode_q <= '0;
            esub_q  <= '0;
        end else begin
            hwi_q <= interrupt_i;
            if (wr_hit(`CSR_ECTL)) begin
                lie_q <= csr_wdata_i[`CSR_ECTL_LIE];
            end
            if (excp_flush_i) begin
                ecode_q <= ecode_i;
                esub_q  <= esubcode_i;
            end else if (wr_hit(`CSR_ESTAT)) begin
                swi_q <= csr_wdata_i[`CSR_ESTAT_SWI];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (excp_flush_i) begin
            era_q <= era_i;
        end else if (wr_hit(`CSR_ERA)) begin
            era_q <= csr_wdata_i;
        end
        if (wr_hit(`CSR_EENTRY)) begin
            eentry_q <= csr_wdata_i[`CSR_EENTRY_VA];
        end
    end

    // bit 12 is the inter-processor interrupt, unused here
    assign is_vec = {1'b0, timer_irq_i, hwi_q, swi_q};

    always_comb begin
        crmd_word                    = `CSR_CRMD_RST;
        crmd_word[`CSR_CRMD_PLV]     = plv_q;
        crmd_word[`CSR_CRMD_IE]      = ie_q;
        prmd_word                    = '0;
        prmd_word[`CSR_PRMD_PPLV]    = pplv_q;
        prmd_word[`CSR_PRMD_PIE]     = pie_q;
        ectl_word                    = '0;
        ectl_word[`CSR_ECTL_LIE]     = lie_q;
        estat_word                   = '0;
        estat_word[`CSR_ESTAT_IS]    = is_vec;
        estat_word[`CSR_ESTAT_ECODE] = ecode_q;
        estat_word[`CSR_ESTAT_ESUB]  = esub_q;
        case (csr_addr_i)
            `CSR_CRMD:   rdata_o = crmd_word;
            `CSR_PRMD:   rdata_o = prmd_word;
            `CSR_ECTL:   rdata_o = ectl_word;
            `CSR_ESTAT:  rdata_o = estat_word;
            `CSR_ERA:    rdata_o = era_q;
            `CSR_EENTRY: rdata_o = eentry_o;
            default:     rdata_o = '0;
        endcase
    end

    assign timer_clr_o = wr_hit(`CSR_TICLR) && csr_wdata_i[`CSR_TICLR_CLR];
    assign has_int_o   = (|(lie_q & is_vec)) && ie_q;
    assign plv_o       = plv_q;
    assign eentry_o    = {eentry_q, 6'b000000};
    assign era_o       = era_q;

endmodule

`default_nettype wire

/* csr_timer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "csr_defines.svh"

module csr_timer (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 csr_we_i,
    input  wire csr_pkg::csr_addr_t csr_addr_i,
    input  wire csr_pkg::csr_data_t csr_wdata_i,
    input  wire                 timer_clr_i,
    output csr_pkg::csr_data_t  rdata_o,
    output logic                timer_irq_o,
    output logic [63:0]         timer_64_o,
    output csr_pkg::csr_data_t  tid_o
);

    import csr_pkg::*;

    csr_data_t   tcfg_q;
    csr_data_t   tval_q;
    csr_data_t   cntc_q;
    csr_data_t   tid_q;
    logic        timer_en_q;
    logic        pending_q;
    logic [63:0] stable_cnt_q;
    logic        tcfg_we;
    logic        tval_zero;
    logic        periodic;

    assign tcfg_we   = csr_we_i && (csr_addr_i == `CSR_TCFG);
    assign tval_zero = (tval_q == '0);
    assign periodic  = tcfg_q[`CSR_TCFG_PERIODIC];

    always_ff @(posedge clk) begin
        if (rst) begin
            tcfg_q     <= '0;
            timer_en_q <= 1'b0;
        end else if (tcfg_we) begin
            tcfg_q     <= csr_wdata_i;
            timer_en_q <= csr_wdata_i[`CSR_TCFG_EN];
        end else if (timer_en_q && tval_zero && !periodic) begin
            // one-shot expired
            timer_en_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (tcfg_we) begin
            tval_q <= {csr_wdata_i[`CSR_TCFG_INITVAL], 2'b00};
        end else if (timer_en_q) begin
            if (!tval_zero) begin
                tval_q <= tval_q - 1'b1;
            end else if (periodic) begin
                tval_q <= {tcfg_q[`CSR_TCFG_INITVAL], 2'b00};
            end else begin
                tval_q <= '1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending_q <= 1'b0;
        end else if (timer_clr_i) begin
            pending_q <= 1'b0;
        end else if (timer_en_q && tval_zero) begin
            pending_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cntc_q       <= '0;
            tid_q        <= '0;
            stable_cnt_q <= '0;
        end else begin
            stable_cnt_q <= stable_cnt_q + 64'd1;
            if (csr_we_i && (csr_addr_i == `CSR_CNTC)) begin
                cntc_q <= csr_wdata_i;
            end
            if (csr_we_i && (csr_addr_i == `CSR_TID)) begin
                tid_q <= csr_wdata_i;
            end
        end
    end

    always_comb begin
        case (csr_addr_i)
            `CSR_TID:   rdata_o = tid_q;
            `CSR_TCFG:  rdata_o = tcfg_q;
            `CSR_TVAL:  rdata_o = tval_q;
            `CSR_CNTC:  rdata_o = cntc_q;
            // write-only clear
            `CSR_TICLR: rdata_o = '0;
            default:    rdata_o = '0;
        endcase
    end

    assign timer_irq_o = pending_q;
    assign tid_o       = tid_q;
    assign timer_64_o  = stable_cnt_q + {{32{cntc_q[31]}}, cntc_q};

endmodule

`default_nettype wire

/* csr_bus_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_bus_fsm (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 wb_cyc_i,
    input  wire                 wb_stb_i,
    input  wire                 wb_we_i,
    input  wire csr_pkg::csr_addr_t wb_adr_i,
    input  wire csr_pkg::csr_data_t wb_dat_i,
    input  wire csr_pkg::csr_data_t trap_rdata_i,
    input  wire csr_pkg::csr_data_t timer_rdata_i,
    input  wire csr_pkg::csr_data_t save_rdata_i,
    output logic                wb_ack_o,
    output csr_pkg::csr_data_t  wb_dat_o,
    output logic                csr_we_o,
    output csr_pkg::csr_addr_t  csr_addr_o,
    output csr_pkg::csr_data_t  csr_wdata_o
);

    import csr_pkg::*;

    bus_state_e state_q;
    logic       req;
    logic       we_q;
    csr_addr_t  addr_q;
    csr_data_t  wdata_q;

    assign req = wb_cyc_i && wb_stb_i && (state_q == BUS_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= BUS_IDLE;
            we_q    <= 1'b0;
        end else if (req) begin
            state_q <= BUS_ACK;
            we_q    <= wb_we_i;
        end else begin
            state_q <= BUS_IDLE;
            we_q    <= 1'b0;
        end
    end

    // read word sampled on the request edge
    always_ff @(posedge clk) begin
        if (req) begin
            addr_q   <= wb_adr_i;
            wdata_q  <= wb_dat_i;
            wb_dat_o <= trap_rdata_i | timer_rdata_i | save_rdata_i;
        end
    end

    // live address while idle so the read decode sees the request
    assign csr_addr_o  = (state_q == BUS_IDLE) ? wb_adr_i : addr_q;
    assign csr_wdata_o = wdata_q;
    assign csr_we_o    = (state_q == BUS_ACK) && we_q;
    assign wb_ack_o    = (state_q == BUS_ACK);

endmodule

`default_nettype wire

/* csr_pkg.sv */
`default_nettype none

`include "csr_defines.svh"

package csr_pkg;

    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [`CSR_DATA_W-1:0] csr_data_t;

    typedef logic [1:0] plv_t;
    typedef logic [5:0] ecode_t;
    typedef logic [8:0] esubcode_t;

    // external interrupt lines, ESTAT IS 10:2
    typedef logic [8:0] hw_int_t;

    typedef enum logic {
        BUS_IDLE,
        BUS_ACK
    } bus_state_e;

endpackage

`default_nettype wire

/* csr_defines.svh */
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

`define CSR_ADDR_W 14
`define CSR_DATA_W 32

// register addresses
`define CSR_CRMD   14'h000
`define CSR_PRMD   14'h001
`define CSR_ECTL   14'h004
`define CSR_ESTAT  14'h005
`define CSR_ERA    14'h006
`define CSR_EENTRY 14'h00c
`define CSR_SAVE0  14'h030
`define CSR_SAVE1  14'h031
`define CSR_SAVE2  14'h032
`define CSR_SAVE3  14'h033
`define CSR_TID    14'h040
`define CSR_TCFG   14'h041
`define CSR_TVAL   14'h042
`define CSR_CNTC   14'h043
`define CSR_TICLR  14'h044

// field positions
`define CSR_CRMD_PLV      1:0
`define CSR_CRMD_IE       2
`define CSR_PRMD_PPLV     1:0
`define CSR_PRMD_PIE      2
`define CSR_ECTL_LIE      12:0
`define CSR_ESTAT_IS      12:0
`define CSR_ESTAT_SWI     1:0
`define CSR_ESTAT_HWI     10:2
`define CSR_ESTAT_TI      11
`define CSR_ESTAT_ECODE   21:16
`define CSR_ESTAT_ESUB    30:22
`define CSR_TCFG_EN       0
`define CSR_TCFG_PERIODIC 1
`define CSR_TCFG_INITVAL  31:2
`define CSR_TICLR_CLR     0
`define CSR_EENTRY_VA     31:6

// DA stays set, no translation in this core
`define CSR_CRMD_RST 32'h0000_0008

`endif
